// ==== common/tiler_pkg.sv ====
/*
 * Tiler package
 * Shared widths, operation codes and element formats of the matrix-multiply
 * tiling front end, plus the state encoding of its sequencer
 */

package tiler_pkg;

  // Matrix size or iteration count
  typedef logic [15:0] dim_t;

  // Residual size along one dimension
  typedef logic [7:0] lftovr_t;

  // Product of iteration counts, truncated
  typedef logic [31:0] count_t;

  // Byte stride
  typedef logic [31:0] stride_t;

  // Operation requested by software, code 7 is unused
  typedef enum logic [2:0] {
    MATMUL = 3'd0,
    GEMM   = 3'd1,
    ADDMAX = 3'd2,
    ADDMIN = 3'd3,
    MULMAX = 3'd4,
    MULMIN = 3'd5,
    MAXMIN = 3'd6
  } gemm_op_e;

  // Element format, FP16 and FP16ALT are two bytes wide
  typedef enum logic [1:0] {
    FP16    = 2'd0,
    FP8     = 2'd1,
    FP16ALT = 2'd2,
    FP8ALT  = 2'd3
  } gemm_fmt_e;

  // Operation of the first FPU stage
  typedef enum logic [1:0] {
    FMADD  = 2'd0,
    ADD    = 2'd1,
    MUL    = 2'd2,
    MINMAX = 2'd3
  } fpu_op_e;

  // Rounding mode of one FPU stage
  typedef enum logic {
    RNE = 1'b0,
    RTZ = 1'b1
  } rnd_mode_e;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    STAGE1 = 2'd1,
    STAGE2 = 2'd2,
    DONE   = 2'd3
  } ctrl_state_e;

endpackage : tiler_pkg

// ==== rtl/seq_mult.sv ====
/*
 * Sequential multiplier
 * Shift-and-add unsigned multiply, one multiplier bit per cycle.
 * Busy for B_WIDTH cycles, done pulses in the last one with the final product
 */

`timescale 1ns/100ps

module seq_mult #(
  parameter int unsigned A_WIDTH = 16,
  parameter int unsigned B_WIDTH = 16
) (
  input  logic                       clk_int,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       start_i,
  input  logic [A_WIDTH-1:0]         a_i,
  input  logic [B_WIDTH-1:0]         b_i,
  output logic                       done_o,
  output logic [A_WIDTH+B_WIDTH-1:0] prod_o
);

  localparam int unsigned P_WIDTH = A_WIDTH + B_WIDTH;
  localparam int unsigned C_WIDTH = (B_WIDTH > 1) ? $clog2(B_WIDTH) : 1;
  localparam logic [C_WIDTH-1:0] LAST_BIT = C_WIDTH'(B_WIDTH - 1);

  logic               busy_q;
  logic [C_WIDTH-1:0] cnt_q;
  logic [P_WIDTH-1:0] mcand_q;
  logic [B_WIDTH-1:0] mplier_q;
  logic [P_WIDTH-1:0] prod_q;
  logic [P_WIDTH-1:0] a_ext;
  logic               last_cycle;

  assign a_ext      = P_WIDTH'(a_i);
  assign last_cycle = busy_q && (cnt_q == LAST_BIT);

  // Bit 0 is accumulated on the start edge, the remaining bits while busy
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      cnt_q    <= '0;
      mcand_q  <= '0;
      mplier_q <= '0;
      prod_q   <= '0;
    end else if (clear_i) begin
      busy_q   <= 1'b0;
      cnt_q    <= '0;
      mcand_q  <= '0;
      mplier_q <= '0;
      prod_q   <= '0;
    end else if (start_i) begin
      busy_q   <= 1'b1;
      cnt_q    <= '0;
      mcand_q  <= a_ext << 1;
      mplier_q <= b_i >> 1;
      prod_q   <= b_i[0] ? a_ext : '0;
    end else if (last_cycle) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q    <= cnt_q + 1'b1;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
      if (mplier_q[0]) begin
        prod_q <= prod_q + mcand_q;
      end
    end
  end

  assign done_o = last_cycle;
  assign prod_o = prod_q;

  // The sequencer never restarts a multiplication in flight
  assert property (@(posedge clk_int) disable iff (!rst_ni) start_i |-> !busy_q)
    else $error("seq_mult: start while busy");

endmodule : seq_mult

// ==== tiler/tiler_dims.sv ====
/*
 * Tiler dimension logic
 * Derives iteration counts, residuals, X row stride and the FPU stage
 * decode from the matrix sizes and the operation code
 */

`timescale 1ns/100ps

module tiler_dims #(
  parameter int unsigned ARRAY_WIDTH  = 12,
  parameter int unsigned ARRAY_HEIGHT = 4,
  parameter int unsigned PIPE_REGS    = 3
) (
  input  tiler_pkg::dim_t      m_size_i,
  input  tiler_pkg::dim_t      k_size_i,
  input  tiler_pkg::dim_t      n_size_i,
  input  tiler_pkg::gemm_op_e  gemm_op_i,
  input  tiler_pkg::gemm_fmt_e gemm_fmt_i,
  output tiler_pkg::dim_t      x_rows_iter_o,
  output tiler_pkg::dim_t      x_cols_iter_o,
  output tiler_pkg::dim_t      w_rows_iter_o,
  output tiler_pkg::dim_t      w_cols_iter_o,
  output tiler_pkg::lftovr_t   x_rows_lftovr_o,
  output tiler_pkg::lftovr_t   x_cols_lftovr_o,
  output tiler_pkg::lftovr_t   w_rows_lftovr_o,
  output tiler_pkg::lftovr_t   w_cols_lftovr_o,
  output tiler_pkg::stride_t   x_d1_stride_o,
  output tiler_pkg::fpu_op_e   stage1_op_o,
  output tiler_pkg::rnd_mode_e stage1_rnd_o,
  output tiler_pkg::rnd_mode_e stage2_rnd_o,
  output logic                 gemm_sel_o
);

  import tiler_pkg::*;

  // Column depth covered by one pass through the pipelined array
  localparam dim_t ARR_W = dim_t'(ARRAY_WIDTH);
  localparam dim_t ARR_H = dim_t'(ARRAY_HEIGHT);
  localparam dim_t DEPTH = dim_t'(ARRAY_HEIGHT * (PIPE_REGS + 1));

  dim_t x_rows_full, x_rows_rem;
  dim_t x_cols_full, x_cols_rem;
  dim_t w_cols_full, w_cols_rem;
  dim_t w_rows_rem;
  logic wide_elem;

  assign x_rows_full = m_size_i / ARR_W;
  assign x_rows_rem  = m_size_i % ARR_W;
  assign x_cols_full = n_size_i / DEPTH;
  assign x_cols_rem  = n_size_i % DEPTH;
  assign w_cols_full = k_size_i / DEPTH;
  assign w_cols_rem  = k_size_i % DEPTH;
  assign w_rows_rem  = n_size_i % ARR_H;

  // Partial tiles take one more iteration
  assign x_rows_iter_o = x_rows_full + dim_t'(x_rows_rem != '0);
  assign x_cols_iter_o = x_cols_full + dim_t'(x_cols_rem != '0);
  assign w_cols_iter_o = w_cols_full + dim_t'(w_cols_rem != '0);

  // W rows padded up to a full array height
  assign w_rows_iter_o = (w_rows_rem != '0) ? n_size_i + ARR_H - w_rows_rem : n_size_i;

  assign x_rows_lftovr_o = lftovr_t'(x_rows_rem);
  assign x_cols_lftovr_o = lftovr_t'(x_cols_rem);
  assign w_rows_lftovr_o = lftovr_t'(w_rows_rem);
  assign w_cols_lftovr_o = lftovr_t'(w_cols_rem);

  // One X row is N elements
  assign wide_elem     = (gemm_fmt_i == FP16) || (gemm_fmt_i == FP16ALT);
  assign x_d1_stride_o = wide_elem ? stride_t'(n_size_i) << 1 : stride_t'(n_size_i);

  always_comb begin
    stage1_op_o  = MINMAX;
    stage1_rnd_o = RNE;
    stage2_rnd_o = RNE;
    case (gemm_op_i)
      MATMUL, GEMM: begin
        stage1_op_o = FMADD;
      end
      ADDMAX: begin
        stage1_op_o  = ADD;
        stage2_rnd_o = RTZ;
      end
      ADDMIN: begin
        stage1_op_o = ADD;
      end
      MULMAX: begin
        stage1_op_o  = MUL;
        stage2_rnd_o = RTZ;
      end
      MULMIN: begin
        stage1_op_o = MUL;
      end
      MAXMIN: begin
        stage1_rnd_o = RTZ;
      end
      default: begin
        stage2_rnd_o = RTZ;
      end
    endcase
  end

  // Plain matmul skips the accumulation with Y
  assign gemm_sel_o = (gemm_op_i != MATMUL);

endmodule : tiler_dims

// ==== tiler/tiler_ctrl.sv ====
/*
 * Tiler sequencer
 * Starts the first multiplier on start_i, both second-stage multipliers on
 * its done pulse, then registers every result and raises valid_o
 */

`timescale 1ns/100ps

module tiler_ctrl (
  input  logic                 clk_int,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  tiler_pkg::dim_t      x_rows_iter_i,
  input  tiler_pkg::dim_t      x_cols_iter_i,
  input  tiler_pkg::dim_t      w_rows_iter_i,
  input  tiler_pkg::dim_t      w_cols_iter_i,
  input  tiler_pkg::lftovr_t   x_rows_lftovr_i,
  input  tiler_pkg::lftovr_t   x_cols_lftovr_i,
  input  tiler_pkg::lftovr_t   w_rows_lftovr_i,
  input  tiler_pkg::lftovr_t   w_cols_lftovr_i,
  input  tiler_pkg::stride_t   x_d1_stride_i,
  input  tiler_pkg::fpu_op_e   stage1_op_i,
  input  tiler_pkg::rnd_mode_e stage1_rnd_i,
  input  tiler_pkg::rnd_mode_e stage2_rnd_i,
  input  logic                 gemm_sel_i,
  input  logic                 m1_done_i,
  input  logic                 m2w_done_i,
  input  logic                 m2x_done_i,
  input  logic [31:0]          m1_prod_i,
  input  logic [47:0]          m2w_prod_i,
  input  logic [47:0]          m2x_prod_i,
  output logic                 m1_start_o,
  output logic                 m2_start_o,
  output tiler_pkg::dim_t      x_rows_iter_o,
  output tiler_pkg::dim_t      x_cols_iter_o,
  output tiler_pkg::dim_t      w_rows_iter_o,
  output tiler_pkg::dim_t      w_cols_iter_o,
  output tiler_pkg::lftovr_t   x_rows_lftovr_o,
  output tiler_pkg::lftovr_t   x_cols_lftovr_o,
  output tiler_pkg::lftovr_t   w_rows_lftovr_o,
  output tiler_pkg::lftovr_t   w_cols_lftovr_o,
  output tiler_pkg::stride_t   x_d1_stride_o,
  output tiler_pkg::fpu_op_e   stage1_op_o,
  output tiler_pkg::rnd_mode_e stage1_rnd_o,
  output tiler_pkg::rnd_mode_e stage2_rnd_o,
  output logic                 gemm_sel_o,
  output tiler_pkg::dim_t      tot_stores_o,
  output tiler_pkg::count_t    w_tot_len_o,
  output tiler_pkg::count_t    tot_x_read_o,
  output logic                 valid_o
);

  import tiler_pkg::*;

  ctrl_state_e state_q, state_d;
  logic        start_ok;
  logic        capture;
  logic        m2_start_q;

  // Restarts are accepted only when no computation is in flight
  assign start_ok = start_i && !clear_i && ((state_q == IDLE) || (state_q == DONE));
  // Both second-stage multipliers run in lockstep
  assign capture  = (state_q == STAGE2) && m2w_done_i && m2x_done_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE: if (start_ok) state_d = STAGE1;
      STAGE1:     if (m1_done_i) state_d = STAGE2;
      STAGE2:     if (capture) state_d = DONE;
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      m2_start_q <= 1'b0;
      valid_o    <= 1'b0;
    end else if (clear_i) begin
      state_q    <= IDLE;
      m2_start_q <= 1'b0;
      valid_o    <= 1'b0;
    end else begin
      state_q    <= state_d;
      m2_start_q <= (state_q == STAGE1) && m1_done_i;
      if (start_ok) begin
        valid_o <= 1'b0;
      end else if (capture) begin
        valid_o <= 1'b1;
      end
    end
  end

  assign m1_start_o = start_ok;
  assign m2_start_o = m2_start_q;

  // Result register, loaded once per computation
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      x_rows_iter_o   <= '0;
      x_cols_iter_o   <= '0;
      w_rows_iter_o   <= '0;
      w_cols_iter_o   <= '0;
      x_rows_lftovr_o <= '0;
      x_cols_lftovr_o <= '0;
      w_rows_lftovr_o <= '0;
      w_cols_lftovr_o <= '0;
      x_d1_stride_o   <= '0;
      stage1_op_o     <= FMADD;
      stage1_rnd_o    <= RNE;
      stage2_rnd_o    <= RNE;
      gemm_sel_o      <= 1'b0;
      tot_stores_o    <= '0;
      w_tot_len_o     <= '0;
      tot_x_read_o    <= '0;
    end else if (clear_i) begin
      x_rows_iter_o   <= '0;
      x_cols_iter_o   <= '0;
      w_rows_iter_o   <= '0;
      w_cols_iter_o   <= '0;
      x_rows_lftovr_o <= '0;
      x_cols_lftovr_o <= '0;
      w_rows_lftovr_o <= '0;
      w_cols_lftovr_o <= '0;
      x_d1_stride_o   <= '0;
      stage1_op_o     <= FMADD;
      stage1_rnd_o    <= RNE;
      stage2_rnd_o    <= RNE;
      gemm_sel_o      <= 1'b0;
      tot_stores_o    <= '0;
      w_tot_len_o     <= '0;
      tot_x_read_o    <= '0;
    end else if (capture) begin
      x_rows_iter_o   <= x_rows_iter_i;
      x_cols_iter_o   <= x_cols_iter_i;
      w_rows_iter_o   <= w_rows_iter_i;
      w_cols_iter_o   <= w_cols_iter_i;
      x_rows_lftovr_o <= x_rows_lftovr_i;
      x_cols_lftovr_o <= x_cols_lftovr_i;
      w_rows_lftovr_o <= w_rows_lftovr_i;
      w_cols_lftovr_o <= w_cols_lftovr_i;
      x_d1_stride_o   <= x_d1_stride_i;
      stage1_op_o     <= stage1_op_i;
      stage1_rnd_o    <= stage1_rnd_i;
      stage2_rnd_o    <= stage2_rnd_i;
      gemm_sel_o      <= gemm_sel_i;
      tot_stores_o    <= m1_prod_i[15:0];
      w_tot_len_o     <= m2w_prod_i[31:0];
      tot_x_read_o    <= m2x_prod_i[31:0];
    end
  end

  // Stage 2 waits for both done pulses, so they must arrive on the same edge
  assert property (@(posedge clk_int) disable iff (!rst_ni)
                   (state_q == STAGE2) |-> (m2w_done_i == m2x_done_i))
    else $error("tiler_ctrl: stage 2 done pulses out of step");

  // Reports a start that arrives while a computation is in flight
  assert property (@(posedge clk_int) disable iff (!rst_ni)
                   start_i |-> (state_q == IDLE) || (state_q == DONE))
    else $warning("tiler_ctrl: start ignored, sequencer busy");

endmodule : tiler_ctrl

// ==== rtl/tiler_top.sv ====
/*
 * Tiler top level
 * Connects the dimension logic, the sequencer and three sequential multipliers
 */

`timescale 1ns/100ps

module tiler_top #(
  parameter int unsigned ARRAY_WIDTH  = 12,
  parameter int unsigned ARRAY_HEIGHT = 4,
  parameter int unsigned PIPE_REGS    = 3
) (
  input  logic                 clk_int,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  tiler_pkg::dim_t      m_size_i,
  input  tiler_pkg::dim_t      k_size_i,
  input  tiler_pkg::dim_t      n_size_i,
  input  tiler_pkg::gemm_op_e  gemm_op_i,
  input  tiler_pkg::gemm_fmt_e gemm_fmt_i,
  output tiler_pkg::dim_t      x_rows_iter_o,
  output tiler_pkg::dim_t      x_cols_iter_o,
  output tiler_pkg::dim_t      w_rows_iter_o,
  output tiler_pkg::dim_t      w_cols_iter_o,
  output tiler_pkg::lftovr_t   x_rows_lftovr_o,
  output tiler_pkg::lftovr_t   x_cols_lftovr_o,
  output tiler_pkg::lftovr_t   w_rows_lftovr_o,
  output tiler_pkg::lftovr_t   w_cols_lftovr_o,
  output tiler_pkg::stride_t   x_d1_stride_o,
  output tiler_pkg::fpu_op_e   stage1_op_o,
  output tiler_pkg::rnd_mode_e stage1_rnd_o,
  output tiler_pkg::rnd_mode_e stage2_rnd_o,
  output logic                 gemm_sel_o,
  output tiler_pkg::dim_t      tot_stores_o,
  output tiler_pkg::count_t    w_tot_len_o,
  output tiler_pkg::count_t    tot_x_read_o,
  output logic                 valid_o
);

  import tiler_pkg::*;

  dim_t      x_rows_iter, x_cols_iter, w_rows_iter, w_cols_iter;
  lftovr_t   x_rows_lftovr, x_cols_lftovr, w_rows_lftovr, w_cols_lftovr;
  stride_t   x_d1_stride;
  fpu_op_e   stage1_op;
  rnd_mode_e stage1_rnd, stage2_rnd;
  logic      gemm_sel;

  logic        m1_start, m2_start;
  logic        m1_done, m2w_done, m2x_done;
  logic [31:0] m1_prod;
  logic [47:0] m2w_prod, m2x_prod;

  tiler_dims #(
    .ARRAY_WIDTH  ( ARRAY_WIDTH  ),
    .ARRAY_HEIGHT ( ARRAY_HEIGHT ),
    .PIPE_REGS    ( PIPE_REGS    )
  ) u_dims (
    .m_size_i        ( m_size_i      ),
    .k_size_i        ( k_size_i      ),
    .n_size_i        ( n_size_i      ),
    .gemm_op_i       ( gemm_op_i     ),
    .gemm_fmt_i      ( gemm_fmt_i    ),
    .x_rows_iter_o   ( x_rows_iter   ),
    .x_cols_iter_o   ( x_cols_iter   ),
    .w_rows_iter_o   ( w_rows_iter   ),
    .w_cols_iter_o   ( w_cols_iter   ),
    .x_rows_lftovr_o ( x_rows_lftovr ),
    .x_cols_lftovr_o ( x_cols_lftovr ),
    .w_rows_lftovr_o ( w_rows_lftovr ),
    .w_cols_lftovr_o ( w_cols_lftovr ),
    .x_d1_stride_o   ( x_d1_stride   ),
    .stage1_op_o     ( stage1_op     ),
    .stage1_rnd_o    ( stage1_rnd    ),
    .stage2_rnd_o    ( stage2_rnd    ),
    .gemm_sel_o      ( gemm_sel      )
  );

  // Stage 1, x_rows by w_cols gives the store count
  seq_mult #(
    .A_WIDTH ( 16 ),
    .B_WIDTH ( 16 )
  ) u_mult_rc (
    .clk_int ( clk_int     ),
    .rst_ni  ( rst_ni      ),
    .clear_i ( clear_i     ),
    .start_i ( m1_start    ),
    .a_i     ( x_rows_iter ),
    .b_i     ( w_cols_iter ),
    .done_o  ( m1_done     ),
    .prod_o  ( m1_prod     )
  );

  // Stage 2, weight length
  seq_mult #(
    .A_WIDTH ( 16 ),
    .B_WIDTH ( 32 )
  ) u_mult_rcw (
    .clk_int ( clk_int     ),
    .rst_ni  ( rst_ni      ),
    .clear_i ( clear_i     ),
    .start_i ( m2_start    ),
    .a_i     ( w_rows_iter ),
    .b_i     ( m1_prod     ),
    .done_o  ( m2w_done    ),
    .prod_o  ( m2w_prod    )
  );

  // Stage 2, X reads
  seq_mult #(
    .A_WIDTH ( 16 ),
    .B_WIDTH ( 32 )
  ) u_mult_rcx (
    .clk_int ( clk_int     ),
    .rst_ni  ( rst_ni      ),
    .clear_i ( clear_i     ),
    .start_i ( m2_start    ),
    .a_i     ( x_cols_iter ),
    .b_i     ( m1_prod     ),
    .done_o  ( m2x_done    ),
    .prod_o  ( m2x_prod    )
  );

  tiler_ctrl u_ctrl (
    .clk_int         ( clk_int         ),
    .rst_ni          ( rst_ni          ),
    .clear_i         ( clear_i         ),
    .start_i         ( start_i         ),
    .x_rows_iter_i   ( x_rows_iter     ),
    .x_cols_iter_i   ( x_cols_iter     ),
    .w_rows_iter_i   ( w_rows_iter     ),
    .w_cols_iter_i   ( w_cols_iter     ),
    .x_rows_lftovr_i ( x_rows_lftovr   ),
    .x_cols_lftovr_i ( x_cols_lftovr   ),
    .w_rows_lftovr_i ( w_rows_lftovr   ),
    .w_cols_lftovr_i ( w_cols_lftovr   ),
    .x_d1_stride_i   ( x_d1_stride     ),
    .stage1_op_i     ( stage1_op       ),
    .stage1_rnd_i    ( stage1_rnd      ),
    .stage2_rnd_i    ( stage2_rnd      ),
    .gemm_sel_i      ( gemm_sel        ),
    .m1_done_i       ( m1_done         ),
    .m2w_done_i      ( m2w_done        ),
    .m2x_done_i      ( m2x_done        ),
    .m1_prod_i       ( m1_prod         ),
    .m2w_prod_i      ( m2w_prod        ),
    .m2x_prod_i      ( m2x_prod        ),
    .m1_start_o      ( m1_start        ),
    .m2_start_o      ( m2_start        ),
    .x_rows_iter_o   ( x_rows_iter_o   ),
    .x_cols_iter_o   ( x_cols_iter_o   ),
    .w_rows_iter_o   ( w_rows_iter_o   ),
    .w_cols_iter_o   ( w_cols_iter_o   ),
    .x_rows_lftovr_o ( x_rows_lftovr_o ),
    .x_cols_lftovr_o ( x_cols_lftovr_o ),
    .w_rows_lftovr_o ( w_rows_lftovr_o ),
    .w_cols_lftovr_o ( w_cols_lftovr_o ),
    .x_d1_stride_o   ( x_d1_stride_o   ),
    .stage1_op_o     ( stage1_op_o     ),
    .stage1_rnd_o    ( stage1_rnd_o    ),
    .stage2_rnd_o    ( stage2_rnd_o    ),
    .gemm_sel_o      ( gemm_sel_o      ),
    .tot_stores_o    ( tot_stores_o    ),
    .w_tot_len_o     ( w_tot_len_o     ),
    .tot_x_read_o    ( tot_x_read_o    ),
    .valid_o         ( valid_o         )
  );

endmodule : tiler_top

// ==== dv/tb_tiler.sv ====
/*
 * Tiler testbench
 * Reads test cases from a data file, runs each one through the tiling
 * front end and compares every registered result, the start-to-valid
 * latency and the clear behaviour with the expected values
 */

`timescale 1ns/100ps

module tb_tiler;

  import tiler_pkg::*;

  localparam int MAX_CASES  = 32;
  localparam int NUM_FIELDS = 21;
  localparam int TIMEOUT    = 200;
  localparam int LATENCY    = 49;
  localparam int RESTART_AT = 10;

  logic      clk_int;
  logic      rst_ni;
  logic      clear_i;
  logic      start_i;
  dim_t      m_size, k_size, n_size;
  gemm_op_e  gemm_op;
  gemm_fmt_e gemm_fmt;

  dim_t      x_rows_iter, x_cols_iter, w_rows_iter, w_cols_iter;
  lftovr_t   x_rows_lftovr, x_cols_lftovr, w_rows_lftovr, w_cols_lftovr;
  stride_t   x_d1_stride;
  fpu_op_e   stage1_op;
  rnd_mode_e stage1_rnd, stage2_rnd;
  logic      gemm_sel;
  dim_t      tot_stores;
  count_t    w_tot_len, tot_x_read;
  logic      valid;

  // Fields per line: M K N op fmt, then the 16 expected outputs
  logic [31:0] case_data [0:MAX_CASES-1][0:NUM_FIELDS-1];
  int          num_cases;
  int          error_count;
  int          tests_run;
  int          pass_count;
  int          fail_count;
  bit          timed_out;

  tiler_top dut_i (
    .clk_int         ( clk_int       ),
    .rst_ni          ( rst_ni        ),
    .clear_i         ( clear_i       ),
    .start_i         ( start_i       ),
    .m_size_i        ( m_size        ),
    .k_size_i        ( k_size        ),
    .n_size_i        ( n_size        ),
    .gemm_op_i       ( gemm_op       ),
    .gemm_fmt_i      ( gemm_fmt      ),
    .x_rows_iter_o   ( x_rows_iter   ),
    .x_cols_iter_o   ( x_cols_iter   ),
    .w_rows_iter_o   ( w_rows_iter   ),
    .w_cols_iter_o   ( w_cols_iter   ),
    .x_rows_lftovr_o ( x_rows_lftovr ),
    .x_cols_lftovr_o ( x_cols_lftovr ),
    .w_rows_lftovr_o ( w_rows_lftovr ),
    .w_cols_lftovr_o ( w_cols_lftovr ),
    .x_d1_stride_o   ( x_d1_stride   ),
    .stage1_op_o     ( stage1_op     ),
    .stage1_rnd_o    ( stage1_rnd    ),
    .stage2_rnd_o    ( stage2_rnd    ),
    .gemm_sel_o      ( gemm_sel      ),
    .tot_stores_o    ( tot_stores    ),
    .w_tot_len_o     ( w_tot_len     ),
    .tot_x_read_o    ( tot_x_read    ),
    .valid_o         ( valid         )
  );

  initial begin
    clk_int = 1'b0;
    forever #20 clk_int = ~clk_int;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("Fail at time %0t: %s is %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  // Every output is zero after reset and after clear
  task automatic check_zero();
    check_value("valid_o", 32'(valid), 32'd0);
    check_value("x_rows_iter_o", 32'(x_rows_iter), 32'd0);
    check_value("x_cols_iter_o", 32'(x_cols_iter), 32'd0);
    check_value("w_rows_iter_o", 32'(w_rows_iter), 32'd0);
    check_value("w_cols_iter_o", 32'(w_cols_iter), 32'd0);
    check_value("x_rows_lftovr_o", 32'(x_rows_lftovr), 32'd0);
    check_value("x_cols_lftovr_o", 32'(x_cols_lftovr), 32'd0);
    check_value("w_rows_lftovr_o", 32'(w_rows_lftovr), 32'd0);
    check_value("w_cols_lftovr_o", 32'(w_cols_lftovr), 32'd0);
    check_value("tot_stores_o", 32'(tot_stores), 32'd0);
    check_value("w_tot_len_o", w_tot_len, 32'd0);
    check_value("tot_x_read_o", tot_x_read, 32'd0);
    check_value("x_d1_stride_o", x_d1_stride, 32'd0);
    check_value("stage1_op_o", 32'(stage1_op), 32'd0);
    check_value("stage1_rnd_o", 32'(stage1_rnd), 32'd0);
    check_value("stage2_rnd_o", 32'(stage2_rnd), 32'd0);
    check_value("gemm_sel_o", 32'(gemm_sel), 32'd0);
  endtask

  task automatic check_outputs(input int idx);
    check_value("x_rows_iter_o", 32'(x_rows_iter), case_data[idx][5]);
    check_value("x_cols_iter_o", 32'(x_cols_iter), case_data[idx][6]);
    check_value("w_rows_iter_o", 32'(w_rows_iter), case_data[idx][7]);
    check_value("w_cols_iter_o", 32'(w_cols_iter), case_data[idx][8]);
    check_value("x_rows_lftovr_o", 32'(x_rows_lftovr), case_data[idx][9]);
    check_value("x_cols_lftovr_o", 32'(x_cols_lftovr), case_data[idx][10]);
    check_value("w_rows_lftovr_o", 32'(w_rows_lftovr), case_data[idx][11]);
    check_value("w_cols_lftovr_o", 32'(w_cols_lftovr), case_data[idx][12]);
    check_value("tot_stores_o", 32'(tot_stores), case_data[idx][13]);
    check_value("w_tot_len_o", w_tot_len, case_data[idx][14]);
    check_value("tot_x_read_o", tot_x_read, case_data[idx][15]);
    check_value("x_d1_stride_o", x_d1_stride, case_data[idx][16]);
    check_value("stage1_op_o", 32'(stage1_op), case_data[idx][17]);
    check_value("stage1_rnd_o", 32'(stage1_rnd), case_data[idx][18]);
    check_value("stage2_rnd_o", 32'(stage2_rnd), case_data[idx][19]);
    check_value("gemm_sel_o", 32'(gemm_sel), case_data[idx][20]);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      pass_count++;
      $display("%s: passed", name);
    end else begin
      fail_count++;
      $display("%s: failed with %0d mismatches", name, error_count - errs_before);
    end
  endtask

  // Lines that do not hold all fields, such as comments, are skipped
  task automatic load_cases();
    int                fd;
    int                code;
    int                n;
    logic [8*256-1:0]  line_buf;
    logic [31:0]       fld [0:NUM_FIELDS-1];
    fd = $fopen("dv/tiler_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test case file dv/tiler_cases.txt");
    end else begin
      while (!$feof(fd) && num_cases < MAX_CASES) begin
        line_buf = '0;
        code = $fgets(line_buf, fd);
        n = $sscanf(line_buf, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                    fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                    fld[14], fld[15], fld[16], fld[17], fld[18], fld[19], fld[20]);
        if (code > 0 && n == NUM_FIELDS) begin
          for (int f = 0; f < NUM_FIELDS; f++) begin
            case_data[num_cases][f] = fld[f];
          end
          num_cases++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Runs one case, optionally with a second start while the sequencer is busy
  task automatic run_case(input int idx, input bit restart);
    int    latency;
    int    errs_before;
    string name;
    errs_before = error_count;
    if (restart) begin
      name = $sformatf("Restart while busy, case %0d repeated", idx + 1);
    end else begin
      name = $sformatf("Case %0d (M=%0d K=%0d N=%0d op=%0d fmt=%0d)", idx + 1,
                       case_data[idx][0], case_data[idx][1], case_data[idx][2],
                       case_data[idx][3], case_data[idx][4]);
    end
    m_size   = case_data[idx][0][15:0];
    k_size   = case_data[idx][1][15:0];
    n_size   = case_data[idx][2][15:0];
    gemm_op  = gemm_op_e'(case_data[idx][3][2:0]);
    gemm_fmt = gemm_fmt_e'(case_data[idx][4][1:0]);
    start_i  = 1'b1;
    @(negedge clk_int);
    start_i = 1'b0;
    latency = 0;
    while (!valid && latency < TIMEOUT) begin
      @(negedge clk_int);
      latency++;
      start_i = restart && (latency == RESTART_AT);
    end
    start_i = 1'b0;
    if (!valid) begin
      error_count++;
      tests_run++;
      fail_count++;
      timed_out = 1'b1;
      $display("%s: valid_o did not rise within %0d cycles, sequencer state %s",
               name, TIMEOUT, dut_i.u_ctrl.state_q.name());
    end else begin
      check_value("valid_o latency", 32'(latency), 32'(LATENCY));
      check_outputs(idx);
      // Results hold without back-pressure
      repeat (3) begin
        @(negedge clk_int);
        check_value("valid_o", 32'(valid), 32'd1);
      end
      check_outputs(idx);
      clear_i = 1'b1;
      @(negedge clk_int);
      clear_i = 1'b0;
      check_zero();
      report_test(name, errs_before);
    end
  endtask

  initial begin
    int errs_before;
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    start_i     = 1'b0;
    m_size      = '0;
    k_size      = '0;
    n_size      = '0;
    gemm_op     = MATMUL;
    gemm_fmt    = FP16;
    num_cases   = 0;
    error_count = 0;
    tests_run   = 0;
    pass_count  = 0;
    fail_count  = 0;
    timed_out   = 1'b0;
    load_cases();
    repeat (10) @(negedge clk_int);
    rst_ni = 1'b1;
    @(negedge clk_int);
    errs_before = error_count;
    check_zero();
    report_test("Reset values", errs_before);
    if (num_cases == 0) begin
      error_count++;
      $display("No test cases were read from dv/tiler_cases.txt");
    end
    for (int i = 0; i < num_cases && !timed_out; i++) begin
      run_case(i, 1'b0);
    end
    if (num_cases > 0 && !timed_out) begin
      run_case(0, 1'b1);
    end
    $display("%0d tests run, %0d passed, %0d failed, %0d mismatches",
             tests_run, pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tb_tiler

// ==== dv/tiler_cases.txt ====
# Inputs: M K N op fmt, then expected x_rows_iter x_cols_iter w_rows_iter w_cols_iter
# x_rows_lftovr x_cols_lftovr w_rows_lftovr w_cols_lftovr
# tot_stores w_tot_len tot_x_read x_d1_stride stage1_op stage1_rnd stage2_rnd gemm_sel
#
# Even sizes, MATMUL, FP16
24 32 16 0 0 2 1 16 2 0 0 0 0 4 64 4 32 0 0 0 0
# Residuals on every dimension, GEMM, FP8
13 17 7 1 1 2 1 8 2 1 7 3 1 4 32 4 7 0 0 0 1
# ADDMAX, FP16ALT
100 50 30 2 2 9 2 32 4 4 14 2 2 36 1152 72 60 1 0 1 1
# Smallest sizes, ADDMIN, FP8ALT
1 1 1 3 3 1 1 4 1 1 1 1 1 1 4 1 1 1 0 0 1
# MULMAX, FP16
48 64 64 4 0 4 4 64 4 0 0 0 0 16 1024 64 128 2 0 1 1
# MULMIN, FP8
35 20 9 5 1 3 1 12 2 11 9 1 4 6 72 6 9 2 0 0 1
# MAXMIN, FP16ALT
12 16 4 6 2 1 1 4 1 0 4 0 0 1 4 1 8 3 1 0 1
# Unused op code 7, FP8ALT
25 33 18 7 3 3 2 20 3 1 2 2 1 9 180 18 18 3 0 1 1

// ==== src.f ====
common/tiler_pkg.sv
rtl/seq_mult.sv
tiler/tiler_dims.sv
tiler/tiler_ctrl.sv
rtl/tiler_top.sv
dv/tb_tiler.sv

// ==== Makefile ====
# Verilator build and run of the tiler testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
TOP       := tb_tiler
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Finished with no errors

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
